//--- hw/core_cfg_pkg.sv
// Core configuration constants
package core_cfg_pkg;

    localparam int XLEN       = 32;
    localparam int REG_AW     = 5;
    localparam int MUL_STAGES = 5;   // product leaves the last stage.

    // major opcodes.
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    localparam logic [6:0] F7_MULDIV = 7'b0000001;
    localparam logic [6:0] F7_SUB    = 7'b0100000;

    // funct3 for the supported R-type and I-type ops.
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

endpackage

//--- hw/core_types_pkg.sv
// Pipeline data types
package core_types_pkg;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_e;

    // decoded instruction with operands already resolved.
    typedef struct packed {
        logic [core_cfg_pkg::REG_AW-1:0] rd;
        logic                            wr_en;
        logic                            is_mul;
        alu_op_e                         alu_op;
        logic [core_cfg_pkg::XLEN-1:0]   op_a;
        logic [core_cfg_pkg::XLEN-1:0]   op_b;
        logic [core_cfg_pkg::XLEN-1:0]   imm;
        logic                            use_imm;
    } uop_t;

    typedef struct packed {
        logic                            valid;
        logic                            is_mul;
        logic [core_cfg_pkg::REG_AW-1:0] addr;
        logic [core_cfg_pkg::XLEN-1:0]   data;
    } wr_src_t;

    typedef struct packed {
        logic                            valid;
        logic [core_cfg_pkg::REG_AW-1:0] rd;
        logic [core_cfg_pkg::XLEN-1:0]   product;
    } mul_slot_t;

    typedef struct packed {
        logic                          en;
        logic [core_cfg_pkg::XLEN-1:0] data;
    } fwd_t;

endpackage

//--- hw/regfile.sv
// Integer register file
`timescale 1ns/100ps

module regfile (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic [core_cfg_pkg::REG_AW-1:0] ra_addr_i,
    input  logic [core_cfg_pkg::REG_AW-1:0] rb_addr_i,
    output logic [core_cfg_pkg::XLEN-1:0]   ra_data_o,
    output logic [core_cfg_pkg::XLEN-1:0]   rb_data_o,
    input  core_types_pkg::wr_src_t         wr_i
);

    logic [core_cfg_pkg::XLEN-1:0] regs_q [2**core_cfg_pkg::REG_AW];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < 2**core_cfg_pkg::REG_AW; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_i.valid && wr_i.addr != '0) begin
            regs_q[wr_i.addr] <= wr_i.data;
        end
    end

    // x0 is hardwired.
    assign ra_data_o = (ra_addr_i == '0) ? '0 : regs_q[ra_addr_i];
    assign rb_data_o = (rb_addr_i == '0) ? '0 : regs_q[rb_addr_i];

endmodule

//--- hw/bypass_ctrl.sv
// Operand bypass controller
`timescale 1ns/100ps

module bypass_ctrl (
    input  logic                                                clk_i,  // not used.
    input  logic                                                rst_i,
    input  logic [core_cfg_pkg::REG_AW-1:0]                     rs1_i,
    input  logic [core_cfg_pkg::REG_AW-1:0]                     rs2_i,
    input  logic [core_cfg_pkg::REG_AW-1:0]                     rd_i,
    input  logic                                                wr_en_i,
    input  logic                                                is_mul_i,
    input  logic                                                dec_valid_i,
    input  core_types_pkg::wr_src_t                             alu_src_i,
    input  core_types_pkg::mul_slot_t [core_cfg_pkg::MUL_STAGES-1:0] mul_slots_i,
    input  core_types_pkg::wr_src_t                             wb_src_i,
    output core_types_pkg::fwd_t                                fwd_a_o,
    output core_types_pkg::fwd_t                                fwd_b_o,
    output logic                                                stall_o
);

    logic waw;
    logic wb_clash;

    // youngest writer wins: alu, then last mul stage, then write-back.
    function automatic core_types_pkg::fwd_t pick_src(
        input logic [core_cfg_pkg::REG_AW-1:0] rs
    );
        core_types_pkg::fwd_t      f;
        core_types_pkg::mul_slot_t last;
        f    = '0;
        last = mul_slots_i[core_cfg_pkg::MUL_STAGES-1];
        if (rs != '0) begin
            if (alu_src_i.valid && alu_src_i.addr == rs) begin
                f.en   = 1'b1;
                f.data = alu_src_i.data;
            end else if (last.valid && last.rd == rs) begin
                f.en   = 1'b1;
                f.data = last.product;
            end else if (wb_src_i.valid && wb_src_i.addr == rs) begin
                f.en   = 1'b1;
                f.data = wb_src_i.data;
            end
        end
        return f;
    endfunction

    // operand still being multiplied, nothing to forward yet.
    function automatic logic mul_busy(input logic [core_cfg_pkg::REG_AW-1:0] rs);
        logic hit;
        hit = 1'b0;
        for (int s = 0; s < core_cfg_pkg::MUL_STAGES - 1; s++) begin
            if (mul_slots_i[s].valid && mul_slots_i[s].rd == rs) begin
                hit = 1'b1;
            end
        end
        return hit && (rs != '0);
    endfunction

    // one writer per register in flight.
    always_comb begin
        waw = alu_src_i.valid && (alu_src_i.addr == rd_i);
        for (int s = 0; s < core_cfg_pkg::MUL_STAGES; s++) begin
            if (mul_slots_i[s].valid && mul_slots_i[s].rd == rd_i) begin
                waw = 1'b1;
            end
        end
        waw = waw && wr_en_i;
    end

    // an alu op issued now would meet the stage 4 multiply at write-back.
    assign wb_clash = !is_mul_i && mul_slots_i[core_cfg_pkg::MUL_STAGES-2].valid;

    always_comb begin
        fwd_a_o = '0;
        fwd_b_o = '0;
        stall_o = 1'b0;
        if (!rst_i && dec_valid_i) begin
            fwd_a_o = pick_src(rs1_i);
            fwd_b_o = pick_src(rs2_i);
            stall_o = mul_busy(rs1_i) || mul_busy(rs2_i) || waw || wb_clash;
        end
    end

endmodule

//--- hw/issue_stage.sv
// Instruction issue stage
`timescale 1ns/100ps

module issue_stage (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic                            issue_req_i,
    input  logic [core_cfg_pkg::XLEN-1:0]   instr_i,
    output logic                            issue_ack_o,
    output logic [core_cfg_pkg::REG_AW-1:0] ra_addr_o,
    output logic [core_cfg_pkg::REG_AW-1:0] rb_addr_o,
    input  logic [core_cfg_pkg::XLEN-1:0]   ra_data_i,
    input  logic [core_cfg_pkg::XLEN-1:0]   rb_data_i,
    input  core_types_pkg::fwd_t            fwd_a_i,
    input  core_types_pkg::fwd_t            fwd_b_i,
    input  logic                            stall_i,
    output logic [core_cfg_pkg::REG_AW-1:0] rs1_o,
    output logic [core_cfg_pkg::REG_AW-1:0] rs2_o,
    output logic [core_cfg_pkg::REG_AW-1:0] rd_o,
    output logic                            wr_en_o,
    output logic                            is_mul_o,
    output logic                            dec_valid_o,
    output core_types_pkg::uop_t            alu_uop_o,
    output logic                            alu_valid_o,
    output core_types_pkg::uop_t            mul_uop_o,
    output logic                            mul_valid_o
);

    typedef enum logic [1:0] {S_IDLE, S_ACKED, S_WAIT_DROP} state_e;

    state_e                  state_q;
    state_e                  state_d;
    logic [6:0]              opcode;
    logic [6:0]              funct7;
    logic [2:0]              funct3;
    logic                    supported;
    logic                    use_imm;
    logic                    fire;
    core_types_pkg::alu_op_e op;
    core_types_pkg::uop_t    uop;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    always_comb begin
        supported = 1'b1;
        is_mul_o  = 1'b0;
        use_imm   = 1'b0;
        op        = core_types_pkg::ALU_ADD;
        rs1_o     = instr_i[19:15];
        rs2_o     = instr_i[24:20];
        case (opcode)
            core_cfg_pkg::OPC_OP: begin
                if (funct7 == core_cfg_pkg::F7_MULDIV) begin
                    is_mul_o  = (funct3 == core_cfg_pkg::F3_ADD);  // plain mul only.
                    supported = is_mul_o;
                end else begin
                    case (funct3)
                        core_cfg_pkg::F3_ADD: op = (funct7 == core_cfg_pkg::F7_SUB) ?
                            core_types_pkg::ALU_SUB : core_types_pkg::ALU_ADD;
                        core_cfg_pkg::F3_XOR: op = core_types_pkg::ALU_XOR;
                        core_cfg_pkg::F3_OR:  op = core_types_pkg::ALU_OR;
                        core_cfg_pkg::F3_AND: op = core_types_pkg::ALU_AND;
                        default:              supported = 1'b0;
                    endcase
                end
            end
            core_cfg_pkg::OPC_OP_IMM: begin
                use_imm   = 1'b1;
                rs2_o     = '0;
                supported = (funct3 == core_cfg_pkg::F3_ADD);  // addi.
            end
            default: supported = 1'b0;
        endcase
        if (!supported) begin
            rs1_o = '0;
            rs2_o = '0;
        end
    end

    assign rd_o        = instr_i[11:7];
    assign wr_en_o     = supported && (rd_o != '0);
    assign ra_addr_o   = rs1_o;
    assign rb_addr_o   = rs2_o;
    assign dec_valid_o = issue_req_i && (state_q == S_IDLE);
    assign fire        = dec_valid_o && !stall_i;

    always_comb begin
        uop.rd      = rd_o;
        uop.wr_en   = wr_en_o;
        uop.is_mul  = is_mul_o;
        uop.alu_op  = op;
        uop.op_a    = fwd_a_i.en ? fwd_a_i.data : ra_data_i;
        uop.op_b    = fwd_b_i.en ? fwd_b_i.data : rb_data_i;
        uop.imm     = {{(core_cfg_pkg::XLEN-12){instr_i[31]}}, instr_i[31:20]};
        uop.use_imm = use_imm;
    end

    // ack handshake, one dispatch per request.
    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE:      if (fire) state_d = S_ACKED;
            S_ACKED:     state_d = issue_req_i ? S_WAIT_DROP : S_IDLE;
            S_WAIT_DROP: if (!issue_req_i) state_d = S_IDLE;
            default:     state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign issue_ack_o = fire || (state_q != S_IDLE);

    assign alu_uop_o   = uop;
    assign mul_uop_o   = uop;
    assign alu_valid_o = fire && !is_mul_o;
    assign mul_valid_o = fire && is_mul_o;

endmodule

//--- hw/alu_stage.sv
// ALU execute stage
`timescale 1ns/100ps

module alu_stage (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  core_types_pkg::uop_t    uop_i,
    input  logic                    valid_i,
    output core_types_pkg::wr_src_t res_o
);

    logic [core_cfg_pkg::XLEN-1:0]   opb;
    logic [core_cfg_pkg::XLEN-1:0]   result;
    logic                            vld_q;
    logic [core_cfg_pkg::REG_AW-1:0] rd_q;
    logic [core_cfg_pkg::XLEN-1:0]   data_q;

    always_comb begin
        opb = uop_i.use_imm ? uop_i.imm : uop_i.op_b;
        case (uop_i.alu_op)
            core_types_pkg::ALU_SUB: result = uop_i.op_a - opb;
            core_types_pkg::ALU_AND: result = uop_i.op_a & opb;
            core_types_pkg::ALU_OR:  result = uop_i.op_a | opb;
            core_types_pkg::ALU_XOR: result = uop_i.op_a ^ opb;
            default:                 result = uop_i.op_a + opb;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            vld_q <= 1'b0;
        end else begin
            vld_q <= valid_i && uop_i.wr_en;  // rd=x0 never shows up.
        end
    end

    always_ff @(posedge clk_i) begin
        rd_q   <= uop_i.rd;
        data_q <= result;
    end

    always_comb begin
        res_o.valid  = vld_q;
        res_o.is_mul = 1'b0;
        res_o.addr   = rd_q;
        res_o.data   = data_q;
    end

endmodule

//--- hw/mul_pipe.sv
// Pipelined multiplier
`timescale 1ns/100ps

module mul_pipe (
    input  logic                                                clk_i,
    input  logic                                                rst_i,
    input  core_types_pkg::uop_t                                uop_i,
    input  logic                                                valid_i,
    output core_types_pkg::mul_slot_t [core_cfg_pkg::MUL_STAGES-1:0] slots_o
);

    logic [core_cfg_pkg::MUL_STAGES-1:0] vld_q;
    logic [core_cfg_pkg::REG_AW-1:0]     rd_q   [core_cfg_pkg::MUL_STAGES];
    logic [core_cfg_pkg::XLEN-1:0]       prod_q [core_cfg_pkg::MUL_STAGES];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[core_cfg_pkg::MUL_STAGES-2:0], valid_i && uop_i.wr_en};
        end
    end

    // stage 1 forms the low half, the rest only carry it along with rd.
    always_ff @(posedge clk_i) begin
        rd_q[0]   <= uop_i.rd;
        prod_q[0] <= uop_i.op_a * uop_i.op_b;
        for (int s = 1; s < core_cfg_pkg::MUL_STAGES; s++) begin
            rd_q[s]   <= rd_q[s-1];
            prod_q[s] <= prod_q[s-1];
        end
    end

    always_comb begin
        for (int s = 0; s < core_cfg_pkg::MUL_STAGES; s++) begin
            slots_o[s].valid   = vld_q[s];
            slots_o[s].rd      = rd_q[s];
            slots_o[s].product = prod_q[s];
        end
    end

endmodule

//--- hw/wb_stage.sv
// Write-back stage
`timescale 1ns/100ps

module wb_stage (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  core_types_pkg::wr_src_t   alu_i,
    input  core_types_pkg::mul_slot_t mul_last_i,
    output core_types_pkg::wr_src_t   wr_o
);

    logic                            vld_q;
    logic                            is_mul_q;
    logic [core_cfg_pkg::REG_AW-1:0] addr_q;
    logic [core_cfg_pkg::XLEN-1:0]   data_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            vld_q <= 1'b0;
        end else begin
            vld_q <= alu_i.valid || mul_last_i.valid;
        end
    end

    // never both valid, issue stalls on that.
    always_ff @(posedge clk_i) begin
        is_mul_q <= mul_last_i.valid;
        addr_q   <= mul_last_i.valid ? mul_last_i.rd : alu_i.addr;
        data_q   <= mul_last_i.valid ? mul_last_i.product : alu_i.data;
    end

    always_comb begin
        wr_o.valid  = vld_q;
        wr_o.is_mul = is_mul_q;
        wr_o.addr   = addr_q;
        wr_o.data   = data_q;
    end

endmodule

//--- hw/exec_core_top.sv
// Execution core top level
`timescale 1ns/100ps

module exec_core_top (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic                            issue_req_i,
    input  logic [core_cfg_pkg::XLEN-1:0]   instr_i,
    output logic                            issue_ack_o,
    output logic                            wb_valid_o,
    output logic [core_cfg_pkg::REG_AW-1:0] wb_addr_o,
    output logic [core_cfg_pkg::XLEN-1:0]   wb_data_o
);

    core_types_pkg::uop_t                                  alu_uop;
    core_types_pkg::uop_t                                  mul_uop;
    core_types_pkg::wr_src_t                               alu_src;
    core_types_pkg::wr_src_t                               wb_src;
    core_types_pkg::mul_slot_t [core_cfg_pkg::MUL_STAGES-1:0] mul_slots;
    core_types_pkg::fwd_t                                  fwd_a;
    core_types_pkg::fwd_t                                  fwd_b;
    logic                                                  alu_valid;
    logic                                                  mul_valid;
    logic                                                  stall;
    logic                                                  dec_valid;
    logic                                                  wr_en;
    logic                                                  is_mul;
    logic [core_cfg_pkg::REG_AW-1:0]                       rs1;
    logic [core_cfg_pkg::REG_AW-1:0]                       rs2;
    logic [core_cfg_pkg::REG_AW-1:0]                       rd;
    logic [core_cfg_pkg::REG_AW-1:0]                       ra_addr;
    logic [core_cfg_pkg::REG_AW-1:0]                       rb_addr;
    logic [core_cfg_pkg::XLEN-1:0]                         ra_data;
    logic [core_cfg_pkg::XLEN-1:0]                         rb_data;

    regfile u_regfile (
        .clk_i, .rst_i,
        .ra_addr_i(ra_addr), .rb_addr_i(rb_addr),
        .ra_data_o(ra_data), .rb_data_o(rb_data),
        .wr_i(wb_src)
    );

    bypass_ctrl u_bypass (
        .clk_i, .rst_i,
        .rs1_i(rs1), .rs2_i(rs2), .rd_i(rd),
        .wr_en_i(wr_en), .is_mul_i(is_mul), .dec_valid_i(dec_valid),
        .alu_src_i(alu_src), .mul_slots_i(mul_slots), .wb_src_i(wb_src),
        .fwd_a_o(fwd_a), .fwd_b_o(fwd_b), .stall_o(stall)
    );

    issue_stage u_issue (
        .clk_i, .rst_i, .issue_req_i, .instr_i, .issue_ack_o,
        .ra_addr_o(ra_addr), .rb_addr_o(rb_addr),
        .ra_data_i(ra_data), .rb_data_i(rb_data),
        .fwd_a_i(fwd_a), .fwd_b_i(fwd_b), .stall_i(stall),
        .rs1_o(rs1), .rs2_o(rs2), .rd_o(rd), .wr_en_o(wr_en),
        .is_mul_o(is_mul), .dec_valid_o(dec_valid),
        .alu_uop_o(alu_uop), .alu_valid_o(alu_valid),
        .mul_uop_o(mul_uop), .mul_valid_o(mul_valid)
    );

    alu_stage u_alu (.clk_i, .rst_i, .uop_i(alu_uop), .valid_i(alu_valid), .res_o(alu_src));

    mul_pipe u_mul (.clk_i, .rst_i, .uop_i(mul_uop), .valid_i(mul_valid), .slots_o(mul_slots));

    wb_stage u_wb (
        .clk_i, .rst_i,
        .alu_i(alu_src), .mul_last_i(mul_slots[core_cfg_pkg::MUL_STAGES-1]),
        .wr_o(wb_src)
    );

    assign wb_valid_o = wb_src.valid;
    assign wb_addr_o  = wb_src.addr;
    assign wb_data_o  = wb_src.data;

endmodule

//--- sim/exec_core_sva.sv
// Execution core protocol checks
`timescale 1ns/100ps

module exec_core_sva (
    input logic                            clk_i,
    input logic                            rst_i,
    input logic                            issue_req_i,
    input logic                            issue_ack_o,
    input logic                            wb_valid_o,
    input logic [core_cfg_pkg::REG_AW-1:0] wb_addr_o
);

    // ack only answers a live request.
    a_ack_rise: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(issue_ack_o) |-> issue_req_i)
        else $error("ack rose without a request");

    a_ack_fall: assert property (@(posedge clk_i) disable iff (rst_i)
        $fell(issue_req_i) |-> ##[0:2] !issue_ack_o)
        else $error("ack still high two cycles after the request fell");

    // x0 writes never leave the core.
    a_wb_x0: assert property (@(posedge clk_i) disable iff (rst_i)
        wb_valid_o |-> (wb_addr_o != '0))
        else $error("write-back to x0");

endmodule

bind exec_core_top exec_core_sva u_sva (.*);

//--- sim/exec_core_tb.sv
// Execution core testbench
`timescale 1ns/100ps

module exec_core_tb;

    localparam int LIMIT = 200;
    localparam int N_STEPS = 12;

    typedef struct packed {
        logic [3:0]  test;
        logic [31:0] instr;
        logic [31:0] exp;
    } step_t;

    logic        clk_i;
    logic        rst_i;
    logic        issue_req_i;
    logic [31:0] instr_i;
    logic        issue_ack_o;
    logic        wb_valid_o;
    logic [4:0]  wb_addr_o;
    logic [31:0] wb_data_o;

    logic [31:0] model_q [32];
    logic [36:0] pend_q [$];   // {rd, value} in program order.
    step_t       steps [N_STEPS];
    logic [31:0] rng_q;
    int          fails;
    int          passes;
    int          wb_seen;
    int          wb_pred;

    exec_core_top u_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, core_cfg_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
        return {imm, rs1, core_cfg_pkg::F3_ADD, rd, core_cfg_pkg::OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] next_rand();
        rng_q = rng_q * 32'd1664525 + 32'd1013904223;
        return rng_q;
    endfunction

    // architectural result from the register model.
    function automatic logic [31:0] ref_result(input logic [31:0] ins);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        a   = model_q[ins[19:15]];
        b   = model_q[ins[24:20]];
        imm = {{20{ins[31]}}, ins[31:20]};
        if (ins[6:0] == core_cfg_pkg::OPC_OP_IMM) return a + imm;
        if (ins[31:25] == core_cfg_pkg::F7_MULDIV) return a * b;
        case (ins[14:12])
            core_cfg_pkg::F3_XOR: return a ^ b;
            core_cfg_pkg::F3_OR:  return a | b;
            core_cfg_pkg::F3_AND: return a & b;
            default: return (ins[31:25] == core_cfg_pkg::F7_SUB) ? a - b : a + b;
        endcase
    endfunction

    task automatic stop_on_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("=== FAIL ===");
        $finish;
    endtask

    task automatic run_instr(input logic [31:0] ins, input logic [31:0] exp, input logic directed);
        int          t;
        logic [31:0] val;
        @(posedge clk_i);
        issue_req_i <= 1'b1;
        instr_i     <= ins;
        t = 0;
        @(negedge clk_i);
        while (!issue_ack_o) begin
            if (t >= LIMIT) stop_on_timeout("issue_ack_o to rise");
            t++;
            @(negedge clk_i);
        end
        val = directed ? exp : ref_result(ins);
        if (ins[11:7] != 5'd0) begin
            model_q[ins[11:7]] = val;
            pend_q.push_back({ins[11:7], val});
            wb_pred++;
        end
        @(posedge clk_i);
        issue_req_i <= 1'b0;
        t = 0;
        @(negedge clk_i);
        while (issue_ack_o) begin
            if (t >= LIMIT) stop_on_timeout("issue_ack_o to fall");
            t++;
            @(negedge clk_i);
        end
    endtask

    task automatic wait_drain();
        int t;
        t = 0;
        while (pend_q.size() != 0) begin
            if (t >= LIMIT) stop_on_timeout("outstanding write-backs");
            t++;
            @(negedge clk_i);
        end
        repeat (4) @(negedge clk_i);   // catch stray writes.
    endtask

    task automatic report_test(input int id, input string name, input int fails_before);
        $display("test %0d %s: %s (%0d errors)", id, name,
                 (fails == fails_before) ? "ok" : "errors", fails - fails_before);
    endtask

    // oldest pending write to that register must match.
    always @(negedge clk_i) begin : wb_monitor
        int idx;
        idx = -1;
        if (!rst_i && wb_valid_o) begin
            wb_seen++;
            for (int i = 0; i < pend_q.size(); i++) begin
                if (idx < 0 && pend_q[i][36:32] == wb_addr_o) idx = i;
            end
            assert (idx >= 0)
            else begin
                $display("unexpected write-back to register %0d", wb_addr_o);
                fails++;
            end
            if (idx >= 0) begin
                assert (wb_data_o == pend_q[idx][31:0]) passes++;
                else begin
                    $display("[FAIL] wb_data_o x%0d got %h expected %h",
                             wb_addr_o, wb_data_o, pend_q[idx][31:0]);
                    fails++;
                end
                pend_q.delete(idx);
            end
        end
    end

    initial begin
        int          f0;
        logic [31:0] r;
        int          kind;
        logic [31:0] ins;
        logic [4:0]  rd_r;
        logic [4:0]  rs1_r;
        logic [4:0]  rs2_r;
        steps[0]  = '{4'd1, addi(5'd1, 5'd0, 12'd5), 32'd5};
        steps[1]  = '{4'd2, addi(5'd2, 5'd1, 12'd3), 32'd8};
        steps[2]  = '{4'd2, r_type(7'd0, core_cfg_pkg::F3_ADD, 5'd3, 5'd2, 5'd1), 32'd13};
        steps[3]  = '{4'd2, r_type(core_cfg_pkg::F7_SUB, core_cfg_pkg::F3_ADD, 5'd4, 5'd3, 5'd2),
                      32'd5};
        steps[4]  = '{4'd2, r_type(7'd0, core_cfg_pkg::F3_XOR, 5'd5, 5'd4, 5'd3), 32'd8};
        steps[5]  = '{4'd2, r_type(7'd0, core_cfg_pkg::F3_OR, 5'd6, 5'd5, 5'd4), 32'd13};
        steps[6]  = '{4'd2, r_type(7'd0, core_cfg_pkg::F3_AND, 5'd7, 5'd6, 5'd3), 32'd13};
        steps[7]  = '{4'd3, addi(5'd8, 5'd0, 12'd7), 32'd7};
        steps[8]  = '{4'd3, r_type(core_cfg_pkg::F7_MULDIV, 3'd0, 5'd9, 5'd3, 5'd8), 32'd91};
        steps[9]  = '{4'd3, r_type(7'd0, core_cfg_pkg::F3_ADD, 5'd10, 5'd9, 5'd1), 32'd96};
        steps[10] = '{4'd4, r_type(core_cfg_pkg::F7_MULDIV, 3'd0, 5'd11, 5'd9, 5'd2), 32'd728};
        steps[11] = '{4'd4, addi(5'd11, 5'd0, 12'd727), 32'd727};  // no operand on x11.
        for (int i = 0; i < 32; i++) model_q[i] = '0;
        rng_q       = 32'h2cf5_561a;
        fails       = 0;
        passes      = 0;
        wb_seen     = 0;
        wb_pred     = 0;
        rst_i       = 1'b1;
        issue_req_i = 1'b0;
        instr_i     = '0;
        repeat (8) @(posedge clk_i);
        rst_i <= 1'b0;
        @(negedge clk_i);
        f0 = fails;
        assert (!issue_ack_o && !wb_valid_o) passes++;
        else begin
            $display("[FAIL] after reset issue_ack_o %h wb_valid_o %h", issue_ack_o, wb_valid_o);
            fails++;
        end
        for (int t = 1; t <= 4; t++) begin
            if (t > 1) f0 = fails;   // test 1 includes the reset check.
            for (int i = 0; i < N_STEPS; i++) begin
                if (steps[i].test == t) run_instr(steps[i].instr, steps[i].exp, 1'b1);
            end
            wait_drain();
            case (t)
                1: report_test(t, "reset and addi", f0);
                2: report_test(t, "alu chain", f0);
                3: report_test(t, "mul then add", f0);
                default: report_test(t, "same rd twice", f0);
            endcase
        end
        // random mix over x0..x7.
        f0 = fails;
        for (int n = 0; n < 200; n++) begin
            r     = next_rand();
            kind  = int'(r[31:24]) % 7;
            rd_r  = {2'b00, r[2:0]};
            rs1_r = {2'b00, r[5:3]};
            rs2_r = {2'b00, r[8:6]};
            case (kind)
                0: ins = r_type(7'd0, core_cfg_pkg::F3_ADD, rd_r, rs1_r, rs2_r);
                1: ins = r_type(core_cfg_pkg::F7_SUB, core_cfg_pkg::F3_ADD, rd_r, rs1_r, rs2_r);
                2: ins = r_type(7'd0, core_cfg_pkg::F3_AND, rd_r, rs1_r, rs2_r);
                3: ins = r_type(7'd0, core_cfg_pkg::F3_OR, rd_r, rs1_r, rs2_r);
                4: ins = r_type(7'd0, core_cfg_pkg::F3_XOR, rd_r, rs1_r, rs2_r);
                5: ins = r_type(core_cfg_pkg::F7_MULDIV, 3'd0, rd_r, rs1_r, rs2_r);
                default: ins = addi(rd_r, rs1_r, r[20:9]);
            endcase
            run_instr(ins, 32'd0, 1'b0);
        end
        wait_drain();
        assert (wb_seen == wb_pred) passes++;
        else begin
            $display("[FAIL] write-back count got %h expected %h", wb_seen, wb_pred);
            fails++;
        end
        report_test(5, "random", f0);
        $display("checks passed %0d failed %0d", passes, fails);
        if (fails == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- src.f
hw/core_cfg_pkg.sv
hw/core_types_pkg.sv
hw/regfile.sv
hw/bypass_ctrl.sv
hw/issue_stage.sv
hw/alu_stage.sv
hw/mul_pipe.sv
hw/wb_stage.sv
hw/exec_core_top.sv
sim/exec_core_sva.sv
sim/exec_core_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module exec_core_tb \
    -f src.f --Mdir obj_dir -o sim_exec
./obj_dir/sim_exec > sim.log 2>&1 || true
cat sim.log
if grep -q "=== FAIL ===" sim.log; then
    exit 1
fi
exit 0
